// ==== src.f ====
source/isaPkg.sv
source/pipePkg.sv
source/programCounter.sv
source/instrMemory.sv
source/hazardDetect.sv
source/controlDecode.sv
source/fetchOutput.sv
source/fetchStage.sv
verification/fetchStageTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the fetch stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module fetchStageTb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/VfetchStageTb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
if ! grep -q "TEST OK" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
exit 0

// ==== verification/fetchStageTb.sv ====
/*
  Testbench for the fetch stage.
  Loads a program through memLoad during reset, then checks every accepted
  output against a table of expected pc, instr, writeReg and control flags.
*/
module fetchStageTb;
    import isaPkg::*;
    import pipePkg::*;

    localparam int progLen = 15;
    localparam int expLen = 15;
    localparam int waitLimit = 400;
    localparam logic [31:0] lfsrTaps = 32'h8020_0003;

    // Test ids
    localparam int tSeq = 0;
    localparam int tDecode = 1;
    localparam int tLoadUse = 2;
    localparam int tHalt = 3;
    localparam int tBack = 4;
    localparam int tRedirect = 5;

    logic     clk;
    logic     reset;
    memLoadT  memLoad;
    redirectT redirect;
    logic     outValid;
    logic     outReady;
    fetchOutT outData;
    logic     halted;

    logic [15:0] progWords [progLen];
    logic [15:0] expPc [expLen];
    logic [15:0] expInstr [expLen];
    logic [2:0]  expReg [expLen];
    // regWrite memEn memWr valToReg aluSrcImm immSel[3] linkReg[2]
    // regJump branch halt siic illegal readsRs
    logic [15:0] expFlags [expLen];
    string       testNames [6];
    int          testErrors [6];
    logic [31:0] lfsr;
    bit          hung;
    int          passed;
    int          failed;
    int          cyc;

    fetchStage i_fetchStage (
        .clk     (clk),
        .reset   (reset),
        .memLoad (memLoad),
        .redirect(redirect),
        .outValid(outValid),
        .outReady(outReady),
        .outData (outData),
        .halted  (halted)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ lfsrTaps) : (s >> 1);
    endfunction

    function automatic logic [15:0] flagsOf(input ctrlT c);
        return {c.regWrite, c.memEnable, c.memWrite, c.valToReg, c.aluSrcImm, c.immSel,
                c.linkReg, c.regJump, c.branch, c.halt, c.siic, c.illegal, c.readsRs};
    endfunction

    task automatic checkValue(input int testId, input string what,
                              input logic [15:0] expected, input logic [15:0] actual);
        if (expected !== actual) begin
            testErrors[testId]++;
            $display("Mismatch %s %s: expected %h, actual %h",
                     testNames[testId], what, expected, actual);
        end
    endtask

    task automatic setEntry(input int idx, input logic [15:0] pc, input logic [15:0] instr,
                            input logic [2:0] reg3, input logic [15:0] flags);
        expPc[idx] = pc;
        expInstr[idx] = instr;
        expReg[idx] = reg3;
        expFlags[idx] = flags;
    endtask

    task automatic fillTables();
        progWords[0] = 16'hC105;  // LBI r1
        progWords[1] = 16'h4143;  // ADDI r2 <- r1
        progWords[2] = 16'hDA2C;  // ALUR r3
        progWords[3] = 16'h8381;  // ST
        progWords[4] = 16'h2010;  // J
        progWords[5] = 16'h2C00;  // JR r4
        progWords[6] = 16'h6504;  // BEQZ r5
        progWords[7] = 16'h1000;  // SIIC
        progWords[8] = 16'hF800;  // Illegal opcode
        progWords[9] = 16'h3002;  // JAL
        progWords[10] = 16'h8E02; // LD r6
        progWords[11] = 16'h4620; // ADDI r1 <- r6, load-use
        progWords[12] = 16'h0800; // NOP
        progWords[13] = 16'h0000; // HALT
        progWords[14] = 16'hC7FF; // Never delivered
        setEntry(0, 16'd0, 16'hC105, 3'd1, 16'h8A00);
        setEntry(1, 16'd2, 16'h4143, 3'd2, 16'h8801);
        setEntry(2, 16'd4, 16'hDA2C, 3'd3, 16'h8001);
        setEntry(3, 16'd6, 16'h8381, 3'd0, 16'h6801);
        setEntry(4, 16'd8, 16'h2010, 3'd0, 16'h0400);
        setEntry(5, 16'd10, 16'h2C00, 3'd0, 16'h0221);
        setEntry(6, 16'd12, 16'h6504, 3'd0, 16'h0211);
        setEntry(7, 16'd14, 16'h1000, 3'd0, 16'h0004);
        setEntry(8, 16'd16, 16'hF800, 3'd0, 16'h0002);
        setEntry(9, 16'd18, 16'h3002, 3'd7, 16'h8440);
        setEntry(10, 16'd20, 16'h8E02, 3'd6, 16'hD801);
        setEntry(11, 16'd22, 16'h0800, 3'd0, 16'h0000); // Bubble at the reader's pc
        setEntry(12, 16'd22, 16'h4620, 3'd1, 16'h8801);
        setEntry(13, 16'd24, 16'h0800, 3'd0, 16'h0000);
        setEntry(14, 16'd26, 16'h0000, 3'd0, 16'h0008);
    endtask

    task automatic drawReady(input bit randomReady);
        if (randomReady) begin
            outReady <= lfsr[0];
            lfsr = lfsrStep(lfsr);
        end else begin
            outReady <= 1'b1;
        end
    endtask

    // Accepts table entries firstIdx..lastIdx in order
    task automatic consume(input int testId, input int firstIdx, input int lastIdx,
                           input bit randomReady);
        int idx;
        int waited;
        int seqId;
        int decId;
        idx = firstIdx;
        waited = 0;
        drawReady(randomReady);
        while (idx <= lastIdx && !hung) begin
            @(posedge clk);
            if (outValid && outReady) begin
                seqId = testId;
                decId = (testId == tSeq) ? tDecode : testId;
                if (testId == tSeq && (idx == 11 || idx == 12)) begin
                    seqId = tLoadUse;
                    decId = tLoadUse;
                end
                checkValue(seqId, $sformatf("pc of entry %0d", idx), expPc[idx], outData.pc);
                checkValue(seqId, $sformatf("instr of entry %0d", idx),
                           expInstr[idx], outData.instr);
                checkValue(decId, $sformatf("flags of entry %0d", idx),
                           expFlags[idx], flagsOf(outData.ctrl));
                if (expFlags[idx][15]) begin
                    checkValue(decId, $sformatf("writeReg of entry %0d", idx),
                               16'(expReg[idx]), 16'(outData.ctrl.writeReg));
                end
                idx++;
                waited = 0;
            end else begin
                waited++;
                if (waited > waitLimit) begin
                    $display("Timeout in %s: no output for entry %0d", testNames[testId], idx);
                    testErrors[testId]++;
                    hung = 1;
                end
            end
            drawReady(randomReady);
        end
    endtask

    task automatic checkHalt();
        int waited;
        int quiet;
        waited = 0;
        while (!halted && !hung) begin
            @(posedge clk);
            waited++;
            if (waited > waitLimit) begin
                $display("Timeout in halt: halted never went high");
                testErrors[tHalt]++;
                hung = 1;
            end
        end
        for (quiet = 0; quiet < 20 && !hung; quiet++) begin
            @(posedge clk);
            if (outValid || !halted) begin
                $display("Halt: output or running state seen after HALT, pc %h", outData.pc);
                testErrors[tHalt]++;
            end
        end
    endtask

    task automatic pulseRedirect(input logic [15:0] target);
        redirect <= '{1'b1, target};
        @(posedge clk);
        redirect <= '0;
    endtask

    task automatic reportTest(input int testId);
        if (testErrors[testId] == 0) begin
            passed++;
        end else begin
            failed++;
        end
        $display("test %s: %s, %0d errors", testNames[testId],
                 (testErrors[testId] == 0) ? "passed" : "failed", testErrors[testId]);
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        memLoad = '0;
        redirect = '0;
        outReady = 1'b0;
        lfsr = 32'd65567;
        hung = 0;
        passed = 0;
        failed = 0;
        testNames = '{"sequential", "decode", "loadUse", "halt", "backPressure", "redirect"};
        testErrors = '{0, 0, 0, 0, 0, 0};
        fillTables();

        // Program goes in while the pc is held at 0
        for (cyc = 0; cyc < 16; cyc++) begin
            @(posedge clk);
            if (cyc < progLen) begin
                memLoad <= '{1'b1, memAddrBits'(cyc), progWords[cyc]};
            end else begin
                memLoad <= '0;
            end
        end
        reset <= 1'b0;

        consume(tSeq, 0, expLen - 1, 1'b0);
        reportTest(tSeq);
        reportTest(tDecode);
        reportTest(tLoadUse);
        checkHalt();
        reportTest(tHalt);

        if (!hung) begin
            pulseRedirect(16'h0000);
            consume(tBack, 0, expLen - 1, 1'b1);
        end
        reportTest(tBack);

        if (!hung) begin
            pulseRedirect(16'h0000);
            consume(tRedirect, 0, 2, 1'b0);
            outReady <= 1'b0; // Nothing pops on the redirect edge
            pulseRedirect(16'd20);
            consume(tRedirect, 10, expLen - 1, 1'b0);
        end
        reportTest(tRedirect);

        $display("tests passed %0d, failed %0d", passed, failed);
        if (failed == 0 && !hung) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== source/fetchStage.sv ====
/*
  Fetch stage top level.
  Pc and instruction RAM feed an in-flight register, the hazard check
  and the decoder, and results queue for decode behind valid/ready.
*/
module fetchStage (
    input  logic              clk,
    input  logic              reset,
    input  pipePkg::memLoadT  memLoad,
    input  pipePkg::redirectT redirect,
    output logic              outValid,
    input  logic              outReady,
    output pipePkg::fetchOutT outData,
    output logic              halted
);
    import isaPkg::*;
    import pipePkg::*;

    logic [15:0] pc;
    logic [15:0] fetched;
    logic [15:0] decodeInstr;
    logic [15:0] inFlightPc;
    logic        inFlightValid;
    logic        advance;
    logic        space;
    logic        pcStall;
    logic        pushValid;
    logic        hazardClear;
    redirectT    pcRedirect;
    ctrlT        ctrl;
    fetchOutT    pushData;

    // External redirect beats the load-use rewind
    assign pcRedirect.valid = redirect.valid || pcStall;
    assign pcRedirect.target = redirect.valid ? redirect.target : inFlightPc;

    assign advance = space && !pcStall && !halted;
    assign pushValid = inFlightValid && !halted && !redirect.valid; // Drop squashed words
    assign hazardClear = reset || redirect.valid; // Redirect also leaves halt

    assign pushData.pc = inFlightPc;
    assign pushData.instr = decodeInstr;
    assign pushData.ctrl = ctrl;

    // Tracks which pc the RAM output belongs to
    always_ff @(posedge clk) begin
        if (reset) begin
            inFlightValid <= 1'b0;
        end else begin
            inFlightValid <= advance && !pcRedirect.valid;
        end
    end

    always_ff @(posedge clk) begin
        inFlightPc <= pc;
    end

    programCounter pcUnit (
        .clk     (clk),
        .reset   (reset),
        .advance (advance),
        .redirect(pcRedirect),
        .pc      (pc)
    );

    instrMemory instrMem (
        .clk  (clk),
        .load (memLoad),
        .pc   (pc),
        .instr(fetched)
    );

    hazardDetect hazard (
        .clk         (clk),
        .reset       (hazardClear),
        .fetched     (fetched),
        .fetchedValid(inFlightValid),
        .issued      (pushValid),
        .issuedCtrl  (ctrl),
        .instr       (decodeInstr),
        .bubble      (),
        .pcStall     (pcStall),
        .halted      (halted)
    );

    controlDecode decode (
        .instr(decodeInstr),
        .ctrl (ctrl)
    );

    fetchOutput outBuf (
        .clk      (clk),
        .reset    (reset),
        .flush    (redirect.valid),
        .pushValid(pushValid),
        .pushData (pushData),
        .space    (space),
        .outValid (outValid),
        .outReady (outReady),
        .outData  (outData)
    );

    // Decode sees a steady item while it holds off, unless a redirect flushes it
    outHeld: assert property (@(posedge clk) disable iff (reset)
        outValid && !outReady && !redirect.valid |=> outValid && $stable(outData))
        else $error("output changed while decode was stalling");

endmodule

// ==== source/fetchOutput.sv ====
/*
  Two-entry FIFO between fetch and decode.
  Space looks one cycle ahead so the pc only advances when the
  word it starts will find a free slot.
*/
module fetchOutput (
    input  logic              clk,
    input  logic              reset,
    input  logic              flush,
    input  logic              pushValid,
    input  pipePkg::fetchOutT pushData,
    output logic              space,
    output logic              outValid,
    input  logic              outReady,
    output pipePkg::fetchOutT outData
);
    import pipePkg::*;

    fetchOutT   slots [2];
    logic       rdPtr;
    logic       wrPtr;
    logic [1:0] count;
    logic [1:0] nextCount;
    logic       pop;
    logic       full;

    assign full = (count == 2'd2);
    assign outValid = (count != 2'd0);
    assign outData = slots[rdPtr];
    assign pop = outValid && outReady;

    // Occupancy after this edge; at most one left keeps a slot for the next fetch
    assign nextCount = count + 2'(pushValid) - 2'(pop);
    assign space = !nextCount[1];

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            count <= 2'd0;
            rdPtr <= 1'b0;
            wrPtr <= 1'b0;
        end else begin
            count <= nextCount;
            if (pushValid) wrPtr <= ~wrPtr;
            if (pop) rdPtr <= ~rdPtr;
        end
    end

    always_ff @(posedge clk) begin
        if (pushValid) begin
            slots[wrPtr] <= pushData;
        end
    end

    // Space from a cycle earlier must have reserved this slot
    noPushWhenFull: assert property (@(posedge clk) disable iff (reset) pushValid |-> !full)
        else $error("push into full fetch buffer");

endmodule

// ==== source/controlDecode.sv ====
/*
  Opcode decoder for the fetch stage.
  Purely combinational; turns one instruction into the control
  bundle and picks the destination register.
*/
module controlDecode (
    input  logic [15:0]  instr,
    output isaPkg::ctrlT ctrl
);
    import isaPkg::*;

    opcodeT  op;
    destSelT destSel;

    assign op = opcodeT'(instr[opHi:opLo]);

    always_comb begin
        ctrl = '0;
        destSel = RS;
        ctrl.readsRs = readsRsOf(op);
        case (op)
            HALT: ctrl.halt = 1'b1;
            NOP: ;
            SIIC: ctrl.siic = 1'b1;
            J: ctrl.immSel = 3'd4;      // disp11
            JR: begin
                ctrl.regJump = 1'b1;
                ctrl.immSel = 3'd2;
            end
            JAL: begin
                ctrl.regWrite = 1'b1;
                ctrl.linkReg = 2'b01; // Write back pc+2
                ctrl.immSel = 3'd4;
                destSel = R7;
            end
            ADDI: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                destSel = RDI;
            end
            BEQZ: begin
                ctrl.branch = 1'b1;
                ctrl.immSel = 3'd2;
            end
            ST: begin
                ctrl.memEnable = 1'b1;
                ctrl.memWrite = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            LD: begin
                ctrl.regWrite = 1'b1;
                ctrl.memEnable = 1'b1;
                ctrl.valToReg = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                destSel = RS;
            end
            LBI: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.immSel = 3'd2;     // imm8
                destSel = RS;
            end
            ALUR: begin
                ctrl.regWrite = 1'b1;
                destSel = RDR;
            end
            default: ctrl.illegal = 1'b1; // No writes of any kind
        endcase

        case (destSel)
            RS:  ctrl.writeReg = instr[rsHi:rsLo];
            RDR: ctrl.writeReg = instr[rdrHi:rdrLo];
            R7:  ctrl.writeReg = linkRegNum;
            RDI: ctrl.writeReg = instr[rdiHi:rdiLo];
            default: ctrl.writeReg = instr[rsHi:rsLo];
        endcase
    end

endmodule

// ==== source/hazardDetect.sv ====
/*
  Load-use check and halt tracking for the fetch stage.
  A word that reads the Rs of the last issued LD is swapped for a NOP
  bubble and the pc is rewound so the reader is fetched again.
*/
module hazardDetect (
    input  logic         clk,
    input  logic         reset,
    input  logic [15:0]  fetched,
    input  logic         fetchedValid,
    input  logic         issued,
    input  isaPkg::ctrlT issuedCtrl,
    output logic [15:0]  instr,
    output logic         bubble,
    output logic         pcStall,
    output logic         halted
);
    import isaPkg::*;

    logic       ldPending;
    logic [2:0] ldDest;
    opcodeT     fetchedOp;
    logic       dependent;

    assign fetchedOp = opcodeT'(fetched[opHi:opLo]);
    assign dependent = ldPending && readsRsOf(fetchedOp) && (fetched[rsHi:rsLo] == ldDest);

    assign bubble = fetchedValid && !halted && dependent;
    assign pcStall = bubble; // Rewind to the dependent word
    assign instr = bubble ? nopWord : fetched;

    always_ff @(posedge clk) begin
        if (reset) begin
            ldPending <= 1'b0;
            halted <= 1'b0;
        end else if (issued) begin
            // Any issue, a bubble included, retires the pending load
            ldPending <= issuedCtrl.memEnable && !issuedCtrl.memWrite;
            if (issuedCtrl.halt) begin
                halted <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issued) begin
            ldDest <= issuedCtrl.writeReg;
        end
    end

    // The issued NOP clears the load, so one bubble per LD
    singleBubble: assert property (@(posedge clk) disable iff (reset) bubble |=> !bubble)
        else $error("load-use bubble repeated");

endmodule

// ==== source/instrMemory.sv ====
/*
  Single-ported instruction RAM, one 16-bit word per entry.
  The load port takes the array while fetch is parked; otherwise
  the word at pc is read with one cycle of latency.
*/
module instrMemory (
    input  logic             clk,
    input  pipePkg::memLoadT load,
    input  logic [15:0]      pc,
    output logic [15:0]      instr
);
    import pipePkg::*;

    logic [15:0] mem [memWords];

    always_ff @(posedge clk) begin
        if (load.enable) begin
            mem[load.addr] <= load.data;
        end else begin
            instr <= mem[pc[memAddrBits:1]]; // Halfword pc to word index
        end
    end

    // Loads only land while the pc is parked in reset or halt
    loadWhileParked: assert property (@(posedge clk) load.enable |=> $stable(pc))
        else $error("instruction load while fetch is running");

endmodule

// ==== source/programCounter.sv ====
/*
  Fetch address register.
  Steps by one halfword instruction when advance is high and
  jumps to the redirect target, which always wins.
*/
module programCounter (
    input  logic              clk,
    input  logic              reset,
    input  logic              advance,
    input  pipePkg::redirectT redirect,
    output logic [15:0]       pc
);

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= 16'h0000;
        end else if (redirect.valid) begin
            pc <= redirect.target;
        end else if (advance) begin
            pc <= pc + 16'd2;
        end
        // Otherwise frozen by stall, halt or back-pressure
    end

    // Targets from execute and the hazard rewind must stay aligned
    pcAligned: assert property (@(posedge clk) disable iff (reset) !pc[0])
        else $error("pc is odd: %h", pc);

endmodule

// ==== source/pipePkg.sv ====
/*
  Pipeline interface types for the fetch stage.
  Redirect from execute, instruction memory load port and the
  item handed to decode.
*/
package pipePkg;

    localparam int memWords = 256;
    localparam int memAddrBits = $clog2(memWords);

    typedef struct packed {
        logic        valid;
        logic [15:0] target;
    } redirectT;

    typedef struct packed {
        logic                   enable;
        logic [memAddrBits-1:0] addr; // Word address
        logic [15:0]            data;
    } memLoadT;

    typedef struct packed {
        logic [15:0]  pc;
        logic [15:0]  instr;
        isaPkg::ctrlT ctrl;
    } fetchOutT;

endpackage

// ==== source/isaPkg.sv ====
/*
  ISA definitions for the 16-bit teaching processor.
  Opcodes, instruction field positions, the decoded control bundle
  and the NOP encoding used for pipeline bubbles.
*/
package isaPkg;

    typedef enum logic [4:0] {
        HALT = 5'b00000,
        NOP  = 5'b00001,
        SIIC = 5'b00010,
        J    = 5'b00100,
        JR   = 5'b00101,
        JAL  = 5'b00110,
        ADDI = 5'b01000,
        BEQZ = 5'b01100,
        ST   = 5'b10000,
        LD   = 5'b10001,
        LBI  = 5'b11000,
        ALUR = 5'b11011
    } opcodeT;

    // Instruction field positions
    localparam int opHi = 15;
    localparam int opLo = 11;
    localparam int rsHi = 10;
    localparam int rsLo = 8;
    localparam int rdiHi = 7; // Rd of I-format
    localparam int rdiLo = 5;
    localparam int rdrHi = 4; // Rd of R-format
    localparam int rdrLo = 2;

    localparam logic [2:0] linkRegNum = 3'd7;
    localparam logic [15:0] nopWord = {NOP, 11'b0};

    typedef enum logic [1:0] {
        RS  = 2'b00,
        RDR = 2'b01,
        R7  = 2'b10,
        RDI = 2'b11
    } destSelT;

    typedef struct packed {
        logic       regWrite;
        logic [2:0] writeReg;
        logic       memEnable;
        logic       memWrite;
        logic       valToReg;  // Load data to register file
        logic       aluSrcImm;
        logic [2:0] immSel;    // 0 imm5, 2 imm8, 4 disp11
        logic [1:0] linkReg;
        logic       regJump;
        logic       branch;
        logic       halt;
        logic       siic;
        logic       illegal;
        logic       readsRs;
    } ctrlT;

    // Opcodes that source register Rs
    function automatic logic readsRsOf(opcodeT op);
        return op inside {JR, ADDI, BEQZ, ST, LD, ALUR};
    endfunction

endpackage
